// File: hdl/keypad_pkg.sv
package keypad_pkg;

    localparam int KP_ROWS = 4;                          // row lines, pulled up
    localparam int KP_COLS = 4;                          // column lines, driven low

    typedef logic [KP_ROWS-1:0] row_vec_t;               // active low
    typedef logic [KP_COLS-1:0] col_vec_t;               // active low
    typedef logic [1:0]         col_idx_t;               // column under scan
    typedef logic [3:0]         key_code_t;              // row*4 + col

    // key positions that are not digits
    localparam key_code_t KEY_ADD   = 4'd3;              // 'A'
    localparam key_code_t KEY_SUB   = 4'd7;              // 'B'
    localparam key_code_t KEY_MUL   = 4'd11;             // 'C'
    localparam key_code_t KEY_EQUAL = 4'd12;             // '*'
    localparam key_code_t KEY_HASH  = 4'd14;             // '#', never delivered
    localparam key_code_t KEY_NEG   = 4'd15;             // 'D'

    localparam int DEBOUNCE_CYCLES = 10;                 // stable cycles before confirm
    localparam int DEB_CNT_W = $clog2(DEBOUNCE_CYCLES + 2); // counter runs one past limit

endpackage

// File: hdl/calc_pkg.sv
package calc_pkg;

    localparam int VALUE_W = 16;                         // operand and result width

    typedef logic [3:0]                 digit_t;         // 0..9
    typedef logic signed [VALUE_W-1:0]  value_t;         // two's complement
    typedef logic signed [2*VALUE_W-1:0] wide_t;         // full width alu result

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    localparam int MAX_DIGITS = 4;                       // extra digits dropped
    localparam int DIGIT_CNT_W = $clog2(MAX_DIGITS + 1);
    localparam value_t DIGIT_BASE = 16'sd10;             // decimal shift

    typedef enum logic [1:0] {
        CS_ENTRY,                                        // taking keys
        CS_EXEC_EQUAL,                                   // alu busy for '='
        CS_EXEC_CHAIN,                                   // alu busy for chained op
        CS_EXEC_NEG                                      // alu busy for negate
    } calc_state_t;

endpackage

// File: hdl/keypad_input_ctrl.sv
`timescale 1ns/1ps

module keypad_input_ctrl (
    input  logic                 clk,
    input  logic                 nRST,
    input  keypad_pkg::row_vec_t row_in,           // rows, low when pressed
    output keypad_pkg::col_vec_t col_out,          // exactly one column low
    output logic                 read_input,       // decoded key pending
    input  logic                 key_read,         // ack pulse from controller
    output calc_pkg::digit_t     keypad_input,
    output calc_pkg::op_t        operator_input,
    output logic                 equal_input
);
    import keypad_pkg::*;
    import calc_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SCAN_COL,
        WAIT_STABLE,
        CONFIRM,
        WAIT_RELEASE
    } scan_state_t;

    scan_state_t          state;
    scan_state_t          next_state;
    col_idx_t             col_idx;                 // column driven low
    logic [DEB_CNT_W-1:0] debounce_cnt;
    key_code_t            key_code;                // latched on first confirm cycle
    key_code_t            enc_code;                // live encode of rows + column
    logic                 code_held;               // key_code valid for this press
    logic                 row_seen;                // any row low

    assign row_seen = ~&row_in;

    always_comb begin
        col_out          = '1;
        col_out[col_idx] = 1'b0;
    end

    // lowest low row wins, nothing low reads as '#'
    always_comb begin
        enc_code = KEY_HASH;
        for (int r = KP_ROWS - 1; r >= 0; r--) begin
            if (!row_in[r])
                enc_code = key_code_t'(r * KP_COLS + int'(col_idx));
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:         next_state = SCAN_COL;
            SCAN_COL:     if (row_seen) next_state = WAIT_STABLE;
            WAIT_STABLE:  if (debounce_cnt >= DEB_CNT_W'(DEBOUNCE_CYCLES))
                              next_state = CONFIRM;
            CONFIRM:      if (key_read || (code_held && key_code == KEY_HASH))
                              next_state = WAIT_RELEASE;   // '#' leaves unacked
            WAIT_RELEASE: if (!row_seen) next_state = IDLE;
            default:      next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= IDLE;
            col_idx      <= '0;
            debounce_cnt <= '0;
            code_held    <= 1'b0;
            read_input   <= 1'b0;
        end else begin
            state <= next_state;
            if (state == SCAN_COL && !row_seen)
                col_idx <= col_idx + 1'b1;              // wraps 3 -> 0
            if (state == WAIT_STABLE)
                debounce_cnt <= row_seen ? debounce_cnt + 1'b1 : '0;
            else
                debounce_cnt <= '0;
            if (state == CONFIRM && !code_held) begin
                code_held  <= 1'b1;
                read_input <= (enc_code != KEY_HASH);   // '#' stays silent
            end
            if (state == WAIT_RELEASE && !row_seen) begin
                code_held  <= 1'b0;
                read_input <= 1'b0;                     // drop after release
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == CONFIRM && !code_held)
            key_code <= enc_code;
    end

    // fixed 4x4 key map
    always_comb begin
        keypad_input   = 4'd0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        case (key_code)
            4'd0:      keypad_input = 4'd1;
            4'd1:      keypad_input = 4'd2;
            4'd2:      keypad_input = 4'd3;
            4'd4:      keypad_input = 4'd4;
            4'd5:      keypad_input = 4'd5;
            4'd6:      keypad_input = 4'd6;
            4'd8:      keypad_input = 4'd7;
            4'd9:      keypad_input = 4'd8;
            4'd10:     keypad_input = 4'd9;
            4'd13:     keypad_input = 4'd0;
            KEY_ADD:   operator_input = OP_ADD;
            KEY_SUB:   operator_input = OP_SUB;
            KEY_MUL:   operator_input = OP_MUL;
            KEY_NEG:   operator_input = OP_NEG;
            KEY_EQUAL: equal_input = 1'b1;
            KEY_HASH:  ;                                // decoded, ignored
            default:   ;
        endcase
    end

    a_one_col_low: assert property (@(posedge clk) disable iff (!nRST)
        $onehot(~col_out));
    a_no_read_in_scan: assert property (@(posedge clk) disable iff (!nRST)
        state == SCAN_COL |-> !read_input);
    a_ack_only_when_valid: assert property (@(posedge clk) disable iff (!nRST)
        key_read |-> read_input);

endmodule

// File: hdl/calc_controller.sv
`timescale 1ns/1ps

module calc_controller (
    input  logic             clk,
    input  logic             nRST,
    input  logic             read_input,        // key pending from input ctrl
    output logic             key_read,          // one cycle ack
    input  calc_pkg::digit_t keypad_input,
    input  calc_pkg::op_t    operator_input,
    input  logic             equal_input,
    output logic             alu_start,
    output calc_pkg::op_t    alu_op,
    output calc_pkg::value_t operand_a,         // also the stored first operand
    output calc_pkg::value_t operand_b,
    input  calc_pkg::value_t alu_result,
    input  logic             alu_overflow,
    input  logic             alu_done,
    output calc_pkg::value_t display_value,
    output logic             overflow
);
    import calc_pkg::*;

    calc_state_t            state;
    value_t                 entry;              // operand being typed
    logic [DIGIT_CNT_W-1:0] digit_cnt;
    op_t                    pending_op;
    op_t                    chain_op;           // op to pend after chained exec
    logic                   result_shown;
    logic                   key_acked;          // acked, waiting for read_input low
    logic                   take_key;
    logic                   is_digit;
    logic                   new_entry;
    logic                   digit_ok;
    logic                   op_key;
    logic                   go_equal;
    logic                   go_neg;
    logic                   go_chain;
    logic                   set_first;
    logic                   launch;
    value_t                 digit_val;
    value_t                 entry_next;

    always_comb begin
        take_key  = read_input && !key_acked && (state == CS_ENTRY);
        is_digit  = (operator_input == OP_NONE) && !equal_input;
        new_entry = result_shown || (digit_cnt == '0);
        digit_ok  = take_key && is_digit
                    && (new_entry || digit_cnt < DIGIT_CNT_W'(MAX_DIGITS));
        op_key    = take_key && !equal_input
                    && operator_input != OP_NONE && operator_input != OP_NEG;
        go_equal  = take_key && equal_input && pending_op != OP_NONE;
        go_neg    = take_key && operator_input == OP_NEG;
        go_chain  = op_key && pending_op != OP_NONE && digit_cnt != '0;
        set_first = op_key && pending_op == OP_NONE;
        launch    = go_equal || go_neg || go_chain;
        digit_val = value_t'(keypad_input);
        if (new_entry)
            entry_next = digit_val;
        else if (entry < 0)
            entry_next = entry * DIGIT_BASE - digit_val;  // keep sign on typing
        else
            entry_next = entry * DIGIT_BASE + digit_val;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state         <= CS_ENTRY;
            entry         <= '0;
            digit_cnt     <= '0;
            pending_op    <= OP_NONE;
            result_shown  <= 1'b0;
            key_acked     <= 1'b0;
            key_read      <= 1'b0;
            alu_start     <= 1'b0;
            display_value <= '0;
            overflow      <= 1'b0;
        end else begin
            key_read  <= take_key;
            alu_start <= launch;
            if (take_key)
                key_acked <= 1'b1;
            else if (!read_input)
                key_acked <= 1'b0;
            case (state)
                CS_ENTRY: begin
                    if (go_equal)
                        state <= CS_EXEC_EQUAL;
                    if (go_chain)
                        state <= CS_EXEC_CHAIN;
                    if (go_neg)
                        state <= CS_EXEC_NEG;
                    if (digit_ok) begin
                        entry         <= entry_next;
                        display_value <= entry_next;
                        digit_cnt     <= new_entry ? DIGIT_CNT_W'(1) : digit_cnt + 1'b1;
                        result_shown  <= 1'b0;
                        if (new_entry)
                            overflow <= 1'b0;           // fresh entry clears flag
                    end
                    if (op_key && !go_chain) begin
                        pending_op <= operator_input;   // replaces an unused op
                        entry      <= '0;
                        digit_cnt  <= '0;
                    end
                    if (set_first) begin
                        display_value <= entry;         // first operand stays shown
                        result_shown  <= 1'b0;
                    end
                end
                CS_EXEC_EQUAL: if (alu_done) begin
                    state         <= CS_ENTRY;
                    entry         <= alu_result;
                    display_value <= alu_result;
                    overflow      <= alu_overflow;
                    pending_op    <= OP_NONE;
                    digit_cnt     <= '0;
                    result_shown  <= 1'b1;
                end
                CS_EXEC_CHAIN: if (alu_done) begin
                    state         <= CS_ENTRY;
                    entry         <= '0;
                    display_value <= alu_result;
                    overflow      <= alu_overflow;
                    pending_op    <= chain_op;
                    digit_cnt     <= '0;
                    result_shown  <= 1'b1;
                end
                CS_EXEC_NEG: if (alu_done) begin
                    state         <= CS_ENTRY;
                    entry         <= alu_result;
                    display_value <= alu_result;
                    overflow      <= alu_overflow;
                end
                default: state <= CS_ENTRY;
            endcase
        end
    end

    // alu operands and the stored first operand
    always_ff @(posedge clk) begin
        if (launch) begin
            alu_op    <= go_neg ? OP_NEG : pending_op;
            operand_b <= (go_neg && result_shown) ? display_value : entry;
            chain_op  <= operator_input;
        end
        if (set_first)
            operand_a <= entry;
        else if (alu_done && (state == CS_EXEC_CHAIN
                 || (state == CS_EXEC_NEG && result_shown && pending_op != OP_NONE)))
            operand_a <= alu_result;                    // result feeds next op
    end

    a_key_read_pulse: assert property (@(posedge clk) disable iff (!nRST)
        key_read |=> !key_read);

endmodule

// File: hdl/calc_alu.sv
`timescale 1ns/1ps

module calc_alu (
    input  logic             clk,
    input  logic             nRST,
    input  logic             alu_start,         // one cycle launch
    input  calc_pkg::op_t    alu_op,
    input  calc_pkg::value_t operand_a,
    input  calc_pkg::value_t operand_b,
    output calc_pkg::value_t alu_result,        // held until next start
    output logic             alu_overflow,
    output logic             alu_done           // start delayed by one
);
    import calc_pkg::*;

    wide_t wide_res;                            // true result, no wrap
    logic  fits;                                // upper bits are sign copies

    always_comb begin
        case (alu_op)
            OP_ADD:  wide_res = wide_t'(operand_a) + wide_t'(operand_b);
            OP_SUB:  wide_res = wide_t'(operand_a) - wide_t'(operand_b);
            OP_MUL:  wide_res = wide_t'(operand_a) * wide_t'(operand_b);
            OP_NEG:  wide_res = -wide_t'(operand_b);
            default: wide_res = wide_t'(operand_b);
        endcase
        fits = (&wide_res[2*VALUE_W-1:VALUE_W-1]) || !(|wide_res[2*VALUE_W-1:VALUE_W-1]);
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            alu_done     <= 1'b0;
            alu_overflow <= 1'b0;
        end else begin
            alu_done <= alu_start;
            if (alu_start)
                alu_overflow <= !fits;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start)
            alu_result <= wide_res[VALUE_W-1:0];        // low 16 bits, wrapped
    end

    a_done_after_start: assert property (@(posedge clk) disable iff (!nRST)
        alu_start |=> alu_done);

endmodule

// File: hdl/keypad_calculator.sv
`timescale 1ns/1ps

module keypad_calculator (
    input  logic                 clk,
    input  logic                 nRST,
    input  keypad_pkg::row_vec_t row_in,        // keypad rows, pulled up
    output keypad_pkg::col_vec_t col_out,       // keypad columns, scanned low
    output calc_pkg::value_t     display_value, // entry or last result
    output logic                 overflow
);
    import calc_pkg::*;

    logic   read_input;
    logic   key_read;
    digit_t keypad_input;
    op_t    operator_input;
    logic   equal_input;
    logic   alu_start;
    op_t    alu_op;
    value_t operand_a;
    value_t operand_b;
    value_t alu_result;
    logic   alu_overflow;
    logic   alu_done;

    keypad_input_ctrl u_input_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .row_in         (row_in),
        .col_out        (col_out),
        .read_input     (read_input),
        .key_read       (key_read),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input)
    );

    calc_controller u_controller (
        .clk            (clk),
        .nRST           (nRST),
        .read_input     (read_input),
        .key_read       (key_read),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .alu_start      (alu_start),
        .alu_op         (alu_op),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .alu_result     (alu_result),
        .alu_overflow   (alu_overflow),
        .alu_done       (alu_done),
        .display_value  (display_value),
        .overflow       (overflow)
    );

    calc_alu u_alu (
        .clk          (clk),
        .nRST         (nRST),
        .alu_start    (alu_start),
        .alu_op       (alu_op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .alu_result   (alu_result),
        .alu_overflow (alu_overflow),
        .alu_done     (alu_done)
    );

endmodule

// File: dv/keypad_model.sv
`timescale 1ns/1ps

module keypad_model #(
    parameter int BOUNCE_LEN = 16                   // cycles of chatter after press
) (
    input  logic                  clk,
    input  logic                  pressed,          // finger on the key
    input  keypad_pkg::key_code_t key,              // row*4 + col
    input  logic                  bounce_en,
    input  keypad_pkg::col_vec_t  col_out,          // from DUT, one low
    output keypad_pkg::row_vec_t  row_in            // to DUT, pulled up
);
    import keypad_pkg::*;

    int   seed = 32'h8a2cab5f;                      // fixed bounce sequence
    int   bounce_left = BOUNCE_LEN;
    int   rnd;
    logic contact = 1'b0;                           // switch closed

    always @(negedge clk) begin
        rnd = $random(seed);
        if (!pressed) begin
            contact     <= 1'b0;
            bounce_left <= BOUNCE_LEN;              // rearm for next press
        end else if (bounce_en && bounce_left > 0) begin
            contact     <= rnd[0];                  // random chatter
            bounce_left <= bounce_left - 1;
        end else begin
            contact <= 1'b1;                        // settled closed
        end
    end

    // closed switch shorts its row to its column
    always_comb begin
        row_in = '1;
        if (contact && !col_out[key[1:0]])
            row_in[key[3:2]] = 1'b0;
    end

endmodule

// File: dv/tb_keypad_calculator.sv
`timescale 1ns/1ps

module tb_keypad_calculator;
    import keypad_pkg::*;
    import calc_pkg::*;

    localparam int CLK_PERIOD     = 40;             // ns
    localparam int RESET_CYCLES   = 8;
    localparam int BOUNCE_LEN     = 16;
    localparam int HOLD           = 30;             // press time after bounce
    localparam int LONG_HOLD      = 200;
    localparam int SETTLE_CYCLES  = 20;             // release to check
    localparam int CYCLES_PER_ROW = 80;             // watchdog budget

    logic      clk;
    logic      nRST;
    row_vec_t  row_in;
    col_vec_t  col_out;
    value_t    display_value;
    logic      overflow;
    logic      pressed;
    key_code_t key;
    logic      bounce_en;

    // stimulus table, one entry per key press
    key_code_t key_q[$];
    logic      bounce_q[$];
    int        hold_q[$];
    value_t    disp_q[$];
    logic      ovf_q[$];

    keypad_calculator i_dut (
        .clk           (clk),
        .nRST          (nRST),
        .row_in        (row_in),
        .col_out       (col_out),
        .display_value (display_value),
        .overflow      (overflow)
    );

    keypad_model #(.BOUNCE_LEN(BOUNCE_LEN)) u_keypad (
        .clk       (clk),
        .pressed   (pressed),
        .key       (key),
        .bounce_en (bounce_en),
        .col_out   (col_out),
        .row_in    (row_in)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input value_t actual, input value_t expected, input string what);
        if (actual !== expected)
            stop_on_error($sformatf("Mismatch at %0t: %s, got %0d, expected %0d",
                                    $time, what, actual, expected));
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            stop_on_error($sformatf("Mismatch at %0t: %s, got %b, expected %b",
                                    $time, what, actual, expected));
    endtask

    task automatic check_col(input col_vec_t actual, input col_vec_t expected, input string what);
        if (actual !== expected)
            stop_on_error($sformatf("Mismatch at %0t: %s, got %b, expected %b",
                                    $time, what, actual, expected));
    endtask

    task automatic add_row(input key_code_t code, input logic bounce, input int hold,
                           input value_t disp, input logic ovf);
        key_q.push_back(code);
        bounce_q.push_back(bounce);
        hold_q.push_back(hold);
        disp_q.push_back(disp);
        ovf_q.push_back(ovf);
    endtask

    task automatic load_table();
        add_row(4'd0,  1'b0, HOLD, 16'sd1, 1'b0);        // 1
        add_row(4'd1,  1'b0, HOLD, 16'sd12, 1'b0);       // 2
        add_row(4'd2,  1'b0, HOLD, 16'sd123, 1'b0);      // 3
        add_row(4'd4,  1'b0, HOLD, 16'sd1234, 1'b0);     // 4
        add_row(4'd5,  1'b0, HOLD, 16'sd1234, 1'b0);     // fifth digit dropped
        add_row(4'd3,  1'b0, HOLD, 16'sd1234, 1'b0);     // + keeps first operand shown
        add_row(4'd13, 1'b0, HOLD, 16'sd0, 1'b0);        // 0
        add_row(4'd12, 1'b0, HOLD, 16'sd1234, 1'b0);     // = 1234 + 0
        add_row(4'd0,  1'b1, HOLD, 16'sd1, 1'b0);        // new entry after result
        add_row(4'd1,  1'b0, HOLD, 16'sd12, 1'b0);
        add_row(4'd3,  1'b0, HOLD, 16'sd12, 1'b0);       // +
        add_row(4'd2,  1'b0, HOLD, 16'sd3, 1'b0);
        add_row(4'd13, 1'b0, HOLD, 16'sd30, 1'b0);
        add_row(4'd12, 1'b0, HOLD, 16'sd42, 1'b0);       // 12 + 30
        add_row(4'd11, 1'b0, HOLD, 16'sd42, 1'b0);       // x on the result
        add_row(4'd1,  1'b0, HOLD, 16'sd2, 1'b0);
        add_row(4'd12, 1'b0, HOLD, 16'sd84, 1'b0);       // 42 x 2
        add_row(4'd7,  1'b0, HOLD, 16'sd84, 1'b0);       // -
        add_row(4'd0,  1'b0, HOLD, 16'sd1, 1'b0);
        add_row(4'd13, 1'b0, HOLD, 16'sd10, 1'b0);
        add_row(4'd13, 1'b0, HOLD, 16'sd100, 1'b0);
        add_row(4'd12, 1'b0, HOLD, -16'sd16, 1'b0);      // 84 - 100
        add_row(4'd8,  1'b1, HOLD, 16'sd7, 1'b0);        // 7
        add_row(4'd15, 1'b0, HOLD, -16'sd7, 1'b0);       // negate entry
        add_row(4'd3,  1'b0, HOLD, -16'sd7, 1'b0);       // +
        add_row(4'd2,  1'b0, HOLD, 16'sd3, 1'b0);
        add_row(4'd12, 1'b0, HOLD, -16'sd4, 1'b0);       // -7 + 3
        add_row(4'd10, 1'b1, HOLD, 16'sd9, 1'b0);
        add_row(4'd10, 1'b0, HOLD, 16'sd99, 1'b0);
        add_row(4'd10, 1'b0, HOLD, 16'sd999, 1'b0);
        add_row(4'd10, 1'b0, HOLD, 16'sd9999, 1'b0);
        add_row(4'd11, 1'b0, HOLD, 16'sd9999, 1'b0);     // x
        add_row(4'd10, 1'b0, HOLD, 16'sd9, 1'b0);
        add_row(4'd10, 1'b0, HOLD, 16'sd99, 1'b0);
        add_row(4'd10, 1'b0, HOLD, 16'sd999, 1'b0);
        add_row(4'd10, 1'b0, HOLD, 16'sd9999, 1'b0);
        add_row(4'd12, 1'b0, HOLD, 16'sh92e1, 1'b1);     // 99980001 mod 2^16
        add_row(4'd5,  1'b0, HOLD, 16'sd5, 1'b0);        // new digit clears flag
        add_row(4'd6,  1'b1, LONG_HOLD, 16'sd56, 1'b0);  // long bouncy press, one digit
        add_row(4'd14, 1'b0, HOLD, 16'sd56, 1'b0);       // '#' ignored
        add_row(4'd9,  1'b1, HOLD, 16'sd568, 1'b0);      // row 2 col 1
        add_row(4'd12, 1'b0, HOLD, 16'sd568, 1'b0);      // = with nothing pending
    endtask

    // press, hold past debounce, release
    task automatic press_key(input key_code_t code, input logic bounce, input int hold);
        @(negedge clk);
        key       <= code;
        bounce_en <= bounce;
        pressed   <= 1'b1;
        repeat (hold + (bounce ? BOUNCE_LEN : 0)) @(negedge clk);
        pressed <= 1'b0;
    endtask

    initial begin
        nRST      = 1'b0;
        pressed   = 1'b0;
        key       = '0;
        bounce_en = 1'b0;
        load_table();
        repeat (RESET_CYCLES) @(negedge clk);
        nRST <= 1'b1;
        @(negedge clk);
        check_value(display_value, '0, "display after reset");
        check_flag(overflow, 1'b0, "overflow after reset");
        check_col(col_out, 4'b1110, "col_out after reset");   // column 0 driven low first
        check_flag(i_dut.read_input, 1'b0, "read_input after reset");
        check_flag(i_dut.key_read, 1'b0, "key_read after reset");
        for (int i = 0; i < key_q.size(); i++) begin
            press_key(key_q[i], bounce_q[i], hold_q[i]);
            repeat (SETTLE_CYCLES) @(negedge clk);
            check_value(display_value, disp_q[i], $sformatf("display after key %0d", i));
            check_flag(overflow, ovf_q[i], $sformatf("overflow after key %0d", i));
        end
        $display("Done: no errors");
        $finish;
    end

    // budget scales with the table
    initial begin
        @(posedge nRST);
        repeat (key_q.size() * CYCLES_PER_ROW) @(posedge clk);
        stop_on_error($sformatf("Timeout: key sequence did not finish within %0d cycles",
                                key_q.size() * CYCLES_PER_ROW));
    end

endmodule

// File: keypad_calculator.f
hdl/keypad_pkg.sv
hdl/calc_pkg.sv
hdl/keypad_input_ctrl.sv
hdl/calc_controller.sv
hdl/calc_alu.sv
hdl/keypad_calculator.sv
dv/keypad_model.sv
dv/tb_keypad_calculator.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the keypad calculator testbench with Verilator, run it, then grep the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_keypad_calculator \
    -f keypad_calculator.f -Mdir obj_dir -o sim_keypad_calculator > build.log 2>&1 \
    && ./obj_dir/sim_keypad_calculator > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }

grep -qx "Done: no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; cat sim.log; exit 1; }
